/* verilog.f */
+incdir+logic
+incdir+verification
logic/ex_op_pkg.sv
logic/ex_bus_pkg.sv
logic/ex_operand_sel.sv
logic/ex_divider.sv
logic/ex_alu.sv
logic/ex_stage.sv
verification/ex_tb.sv

/* verification/ex_tb_ref.svh */
`ifndef EX_TB_REF_SVH
`define EX_TB_REF_SVH

// expected stage outputs for one request, from the architectural rules
function automatic void ex_ref(
    input  ex_req_t                 rq,
    input  logic [`EX_HILO_W-1:0]   hilo_c,
    input  hilo_wr_t                mem_hw,
    input  hilo_wr_t                wb_hw,
    input  logic [`EX_DATA_W-1:0]   cp0_c,
    input  cp0_wr_t                 mem_cw,
    input  cp0_wr_t                 wb_cw,
    output ex_res_t                 res,
    output hilo_wr_t                hw,
    output cp0_wr_t                 cw
);
    logic [`EX_HILO_W-1:0]  cur_hilo;
    logic [`EX_DATA_W-1:0]  cur_cp0;
    logic [`EX_DATA_W-1:0]  a;
    logic [`EX_DATA_W-1:0]  b;
    logic [`EX_DATA_W-1:0]  am;
    logic [`EX_DATA_W-1:0]  bm;
    logic [`EX_DATA_W-1:0]  q;
    logic [`EX_DATA_W-1:0]  r;
    logic [`EX_DATA_W:0]    wide;
    logic [`EX_HILO_W-1:0]  prod;
    logic                   ovf;
    logic                   an;
    logic                   bn;

    // memory stage is younger than write-back
    if (mem_hw.we) cur_hilo = {mem_hw.hi, mem_hw.lo};
    else if (wb_hw.we) cur_hilo = {wb_hw.hi, wb_hw.lo};
    else cur_hilo = hilo_c;
    if (mem_cw.we && mem_cw.addr == rq.rd) cur_cp0 = mem_cw.data;
    else if (wb_cw.we && wb_cw.addr == rq.rd) cur_cp0 = wb_cw.data;
    else cur_cp0 = cp0_c;

    a   = rq.reg1;
    b   = rq.reg2;
    ovf = 1'b0;
    hw  = '0;
    cw  = '0;
    res = '0;
    case (rq.aluop)
        OP_OR:    res.wdata = a | b;
        OP_AND:   res.wdata = a & b;
        OP_XOR:   res.wdata = a ^ b;
        OP_NOR:   res.wdata = ~(a | b);
        OP_SLL:   res.wdata = b << a[4:0];
        OP_SRL:   res.wdata = b >> a[4:0];
        OP_SRA:   res.wdata = $signed(b) >>> a[4:0];
        OP_ADD, OP_ADDU: begin
            wide      = {a[`EX_DATA_W-1], a} + {b[`EX_DATA_W-1], b};   // 33-bit signed sum
            res.wdata = wide[`EX_DATA_W-1:0];
            ovf       = (rq.aluop == OP_ADD) && (wide[`EX_DATA_W] != wide[`EX_DATA_W-1]);
        end
        OP_SUB, OP_SUBU: begin
            wide      = {a[`EX_DATA_W-1], a} - {b[`EX_DATA_W-1], b};
            res.wdata = wide[`EX_DATA_W-1:0];
            ovf       = (rq.aluop == OP_SUB) && (wide[`EX_DATA_W] != wide[`EX_DATA_W-1]);
        end
        OP_SLT:   res.wdata = {31'b0, $signed(a) < $signed(b)};
        OP_SLTU:  res.wdata = {31'b0, a < b};
        OP_MULT, OP_MULTU: begin
            if (rq.aluop == OP_MULT) prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
            else prod = {32'b0, a} * {32'b0, b};
            res.wdata = prod[31:0];
            hw        = '{we: 1'b1, hi: prod[63:32], lo: prod[31:0]};
        end
        OP_DIV, OP_DIVU: begin
            an = (rq.aluop == OP_DIV) && a[31];
            bn = (rq.aluop == OP_DIV) && b[31];
            am = an ? -a : a;
            bm = bn ? -b : b;
            if (b == '0) begin
                q = '1;     // divide by zero
                r = a;
            end else begin
                q = (an ^ bn) ? -(am / bm) : am / bm;
                r = an ? -(am % bm) : am % bm;
            end
            res.wdata = q;
            hw        = '{we: 1'b1, hi: r, lo: q};
        end
        OP_MFHI:  res.wdata = cur_hilo[63:32];
        OP_MFLO:  res.wdata = cur_hilo[31:0];
        OP_MTHI: begin
            res.wdata = a;
            hw        = '{we: 1'b1, hi: a, lo: cur_hilo[31:0]};
        end
        OP_MTLO: begin
            res.wdata = a;
            hw        = '{we: 1'b1, hi: cur_hilo[63:32], lo: a};
        end
        OP_MFC0:  res.wdata = cur_cp0;
        OP_MTC0:  cw = '{we: 1'b1, addr: rq.rd, data: b};
        default:  res.wdata = '0;
    endcase

    res.wd           = rq.wd;
    res.wreg         = rq.wreg && !ovf;
    res.exc_type     = rq.exc_type;
    res.instr_addr   = rq.instr_addr;
    res.in_delayslot = rq.in_delayslot;
    if (ovf) res.exc_type[`EX_EXC_OVF_BIT] = 1'b1;
endfunction

`endif

/* verification/ex_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_tb
    import ex_op_pkg::*;
    import ex_bus_pkg::*;
();

    // ~400 single-cycle ops plus 40 divides of 34 cycles, with margin
    localparam int CYCLE_LIMIT = 6000;

    localparam alu_op_e MOVE_OPS [4] = '{OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO};
    localparam alu_op_e OVF_OPS [4]  = '{OP_ADD, OP_ADDU, OP_SUB, OP_SUBU};
    localparam logic [31:0] OVF_A [4] = '{32'h7fffffff, 32'h80000000, 32'h80000000, 32'h7fffffff};
    localparam logic [31:0] OVF_B [4] = '{32'h00000001, 32'hffffffff, 32'h00000001, 32'hffffffff};

    logic                       clk;
    logic                       rst_n;
    ex_req_t                    req;
    logic [`EX_HILO_W-1:0]      hilo;
    hilo_wr_t                   mem_hilo;
    hilo_wr_t                   wb_hilo;
    logic [`EX_DATA_W-1:0]      cp0_rdata;
    cp0_wr_t                    mem_cp0;
    cp0_wr_t                    wb_cp0;

    ex_res_t                    res;
    hilo_wr_t                   hilo_wr;
    cp0_wr_t                    cp0_wr;
    logic [`EX_CP0_ADDR_W-1:0]  cp0_raddr;
    logic                       ok;

    // side inputs staged for the next drive
    logic [`EX_HILO_W-1:0]      stg_hilo;
    hilo_wr_t                   stg_mem_hilo;
    hilo_wr_t                   stg_wb_hilo;
    logic [`EX_DATA_W-1:0]      stg_cp0_rdata;
    cp0_wr_t                    stg_mem_cp0;
    cp0_wr_t                    stg_wb_cp0;

    integer                     seed;
    string                      test_name;
    int                         n_sent;
    int                         n_done;
    int                         n_errors;
    int                         cycles;

    `include "ex_tb_ref.svh"

    ex_stage dut0 (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .req_i       (req),
        .hilo_i      (hilo),
        .mem_hilo_i  (mem_hilo),
        .wb_hilo_i   (wb_hilo),
        .cp0_rdata_i (cp0_rdata),
        .mem_cp0_i   (mem_cp0),
        .wb_cp0_i    (wb_cp0),
        .res_o       (res),
        .hilo_wr_o   (hilo_wr),
        .cp0_wr_o    (cp0_wr),
        .cp0_raddr_o (cp0_raddr),
        .ok_o        (ok)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] rnd32();
        rnd32 = $random(seed);
    endfunction

    function automatic ex_req_t rand_req(input alu_op_e op);
        ex_req_t    r;
        logic [31:0] x;
        x              = rnd32();
        r.aluop        = op;
        r.reg1         = rnd32();
        r.reg2         = rnd32();
        r.wd           = x[4:0];
        r.wreg         = x[5];
        r.rd           = x[10:6];
        r.in_delayslot = x[11];
        r.exc_type     = rnd32();
        r.instr_addr   = rnd32() & ~32'h3;          // word aligned
        return r;
    endfunction

    function automatic alu_op_e rand_simple_op();
        return alu_op_e'(5'(1 + rnd32() % 13));    // OR through SLTU
    endfunction

    task automatic randomize_side();
        stg_hilo      = {rnd32(), rnd32()};
        stg_mem_hilo  = '{we: 1'b0, hi: rnd32(), lo: rnd32()};
        stg_wb_hilo   = '{we: 1'b0, hi: rnd32(), lo: rnd32()};
        stg_cp0_rdata = rnd32();
        stg_mem_cp0   = '{we: 1'b0, addr: 5'(rnd32()), data: rnd32()};
        stg_wb_cp0    = '{we: 1'b0, addr: 5'(rnd32()), data: rnd32()};
    endtask

    // present one request and wait until the compare process has taken it
    task automatic apply(input string name, input ex_req_t r);
        @(posedge clk);
        #1;
        req       = r;
        hilo      = stg_hilo;
        mem_hilo  = stg_mem_hilo;
        wb_hilo   = stg_wb_hilo;
        cp0_rdata = stg_cp0_rdata;
        mem_cp0   = stg_mem_cp0;
        wb_cp0    = stg_wb_cp0;
        test_name = name;
        n_sent++;
        wait (n_done == n_sent);
    endtask

    task automatic report_mismatch(input string field, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        $display("Fail %s %s: expected %h, actual %h", test_name, field, exp_v, act_v);
        n_errors++;
    endtask

    task automatic check_outputs();
        ex_res_t    exp_res;
        hilo_wr_t   exp_hilo;
        cp0_wr_t    exp_cp0;
        ex_ref(req, hilo, mem_hilo, wb_hilo, cp0_rdata, mem_cp0, wb_cp0,
               exp_res, exp_hilo, exp_cp0);
        if (res.wdata !== exp_res.wdata) report_mismatch("wdata", exp_res.wdata, res.wdata);
        if (res.wreg !== exp_res.wreg) report_mismatch("wreg", exp_res.wreg, res.wreg);
        if (res.exc_type !== exp_res.exc_type) begin
            report_mismatch("exc_type", exp_res.exc_type, res.exc_type);
        end
        if ({res.wd, res.instr_addr, res.in_delayslot} !==
            {exp_res.wd, exp_res.instr_addr, exp_res.in_delayslot}) begin
            report_mismatch("passthrough", {exp_res.wd, exp_res.instr_addr, exp_res.in_delayslot},
                            {res.wd, res.instr_addr, res.in_delayslot});
        end
        if (hilo_wr.we !== exp_hilo.we) report_mismatch("hilo_we", exp_hilo.we, hilo_wr.we);
        else if (exp_hilo.we && {hilo_wr.hi, hilo_wr.lo} !== {exp_hilo.hi, exp_hilo.lo}) begin
            report_mismatch("hilo", {exp_hilo.hi, exp_hilo.lo}, {hilo_wr.hi, hilo_wr.lo});
        end
        if (cp0_wr.we !== exp_cp0.we) report_mismatch("cp0_we", exp_cp0.we, cp0_wr.we);
        else if (exp_cp0.we && {cp0_wr.addr, cp0_wr.data} !== {exp_cp0.addr, exp_cp0.data}) begin
            report_mismatch("cp0_wr", {exp_cp0.addr, exp_cp0.data}, {cp0_wr.addr, cp0_wr.data});
        end
        if (cp0_raddr !== req.rd) report_mismatch("cp0_raddr", req.rd, cp0_raddr);
    endtask

    // sample 1 ns before each rising edge
    initial begin : compare
        int     waited;
        logic   is_div;
        waited = 0;
        forever begin
            @(posedge clk);
            #3;
            if (n_done != n_sent) begin
                is_div = (req.aluop == OP_DIV) || (req.aluop == OP_DIVU);
                if (ok !== 1'b1) begin
                    waited++;
                    if (!is_div) begin
                        $display("Error %s: ok_o low for a single-cycle op", test_name);
                        n_errors++;
                        waited = 0;
                        n_done++;
                    end
                end else begin
                    if (is_div && waited == 0) begin
                        $display("Error %s: ok_o did not drop while the divide ran", test_name);
                        n_errors++;
                    end
                    check_outputs();
                    waited = 0;
                    n_done++;
                end
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, ok_o never returned high", cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        ex_req_t    r;
        logic [31:0] x;
        seed      = 34322;
        n_sent    = 0;
        n_done    = 0;
        n_errors  = 0;
        test_name = "reset";
        rst_n     = 1'b0;
        req       = '0;
        hilo      = '0;
        mem_hilo  = '0;
        wb_hilo   = '0;
        cp0_rdata = '0;
        mem_cp0   = '0;
        wb_cp0    = '0;
        stg_hilo      = '0;
        stg_mem_hilo  = '0;
        stg_wb_hilo   = '0;
        stg_cp0_rdata = '0;
        stg_mem_cp0   = '0;
        stg_wb_cp0    = '0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        r = '0;                                     // nop, all enables low
        apply("reset_nop", r);

        for (int i = 0; i < 200; i++) begin
            randomize_side();
            apply("random_simple", rand_req(rand_simple_op()));
        end

        for (int k = 0; k < 4; k++) begin
            for (int c = 0; c < 4; c++) begin
                r          = rand_req(OVF_OPS[c]);
                r.reg1     = OVF_A[k];
                r.reg2     = OVF_B[k];
                r.wreg     = 1'b1;
                r.exc_type[`EX_EXC_OVF_BIT] = 1'b0;
                apply("overflow", r);
            end
        end

        for (int i = 0; i < 40; i++) begin
            randomize_side();
            apply("multiply", rand_req(i[0] ? OP_MULTU : OP_MULT));
        end

        // none, write-back only, memory only, both
        for (int k = 0; k < 4; k++) begin
            for (int c = 0; c < 4; c++) begin
                randomize_side();
                stg_mem_hilo.we = c[1];
                stg_wb_hilo.we  = c[0];
                apply("hilo_forward", rand_req(MOVE_OPS[k]));
            end
        end

        for (int i = 0; i < 40; i++) begin
            randomize_side();
            r = rand_req(rnd32() & 1 ? OP_DIV : OP_DIVU);
            if (i % 8 == 0) r.reg2 = '0;
            else if (i % 4 == 1) r.reg2 = {{24{r.reg2[31]}}, r.reg2[7:0]};   // small divisor
            apply("divide", r);
            randomize_side();
            apply("div_follow", rand_req(rand_simple_op()));
        end

        for (int i = 0; i < 8; i++) begin
            randomize_side();
            apply("mtc0", rand_req(OP_MTC0));
        end

        for (int i = 0; i < 32; i++) begin
            randomize_side();
            r = rand_req(OP_MFC0);
            x = rnd32();
            stg_mem_cp0.we   = x[0];
            stg_wb_cp0.we    = x[1];
            stg_mem_cp0.addr = x[2] ? r.rd : r.rd ^ 5'd1;
            stg_wb_cp0.addr  = x[3] ? r.rd : r.rd ^ 5'd2;
            apply("mfc0", r);
        end

        $display("checks: %0d, errors: %0d", n_done, n_errors);
        if (n_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_stage
    import ex_bus_pkg::*;
(
    input  wire                         clk_i,
    input  wire                         rst_n_i,

    input  wire ex_req_t                req_i,
    input  wire [`EX_HILO_W-1:0]        hilo_i,
    input  wire hilo_wr_t               mem_hilo_i,
    input  wire hilo_wr_t               wb_hilo_i,
    input  wire [`EX_DATA_W-1:0]        cp0_rdata_i,
    input  wire cp0_wr_t                mem_cp0_i,
    input  wire cp0_wr_t                wb_cp0_i,

    output ex_res_t                     res_o,
    output hilo_wr_t                    hilo_wr_o,
    output cp0_wr_t                     cp0_wr_o,
    output logic [`EX_CP0_ADDR_W-1:0]   cp0_raddr_o,
    output logic                        ok_o        // low stalls the pipeline
);

    logic [`EX_DATA_W-1:0]  op1;
    logic [`EX_DATA_W-1:0]  op2;
    logic [`EX_HILO_W-1:0]  hilo_fwd;
    logic [`EX_DATA_W-1:0]  cp0_fwd;

    assign cp0_raddr_o = req_i.rd;

    ex_operand_sel opsel0 (
        .aluop_i     (req_i.aluop),
        .reg1_i      (req_i.reg1),
        .reg2_i      (req_i.reg2),
        .hilo_i      (hilo_i),
        .mem_hilo_i  (mem_hilo_i),
        .wb_hilo_i   (wb_hilo_i),
        .rd_i        (req_i.rd),
        .cp0_rdata_i (cp0_rdata_i),
        .mem_cp0_i   (mem_cp0_i),
        .wb_cp0_i    (wb_cp0_i),
        .op1_o       (op1),
        .op2_o       (op2),
        .hilo_o      (hilo_fwd),
        .cp0_o       (cp0_fwd)
    );

    ex_alu alu0 (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (req_i),
        .op1_i     (op1),
        .op2_i     (op2),
        .hilo_i    (hilo_fwd),
        .cp0_i     (cp0_fwd),
        .res_o     (res_o),
        .hilo_wr_o (hilo_wr_o),
        .cp0_wr_o  (cp0_wr_o),
        .ok_o      (ok_o)
    );

endmodule

`default_nettype wire

/* logic/ex_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_alu
    import ex_op_pkg::*;
    import ex_bus_pkg::*;
(
    input  wire                     clk_i,
    input  wire                     rst_n_i,

    input  wire ex_req_t            req_i,
    input  wire [`EX_DATA_W-1:0]    op1_i,
    input  wire [`EX_DATA_W-1:0]    op2_i,
    input  wire [`EX_HILO_W-1:0]    hilo_i,     // already forwarded
    input  wire [`EX_DATA_W-1:0]    cp0_i,

    output ex_res_t                 res_o,
    output hilo_wr_t                hilo_wr_o,
    output cp0_wr_t                 cp0_wr_o,
    output logic                    ok_o
);

    localparam int W = `EX_DATA_W;

    alu_grp_e           grp;
    logic [W-1:0]       grp_res;
    logic [W-1:0]       sum;
    logic [W-1:0]       dif;
    logic               ovf;
    logic               mul_sgn;
    logic [2*W-1:0]     mul_a;
    logic [2*W-1:0]     mul_b;
    logic [2*W-1:0]     product;

    logic               div_start;
    logic               div_signed;
    logic               div_busy;
    logic               div_done;
    logic [W-1:0]       div_quot;
    logic [W-1:0]       div_rem;

    always_comb begin
        case (req_i.aluop)
            OP_OR, OP_AND, OP_XOR, OP_NOR:             grp = GRP_LOGIC;
            OP_SLL, OP_SRL, OP_SRA:                    grp = GRP_SHIFT;
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
            OP_SLT, OP_SLTU:                           grp = GRP_ARITH;
            OP_MULT, OP_MULTU:                         grp = GRP_MUL;
            OP_DIV, OP_DIVU:                           grp = GRP_DIV;
            OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO:        grp = GRP_MOVE;
            OP_MFC0, OP_MTC0:                          grp = GRP_CP0;
            default:                                   grp = GRP_NONE;
        endcase
    end

    assign sum = op1_i + op2_i;
    assign dif = op1_i - op2_i;

    // only the trapping forms report overflow
    always_comb begin
        case (req_i.aluop)
            OP_ADD:  ovf = (op1_i[W-1] == op2_i[W-1]) && (sum[W-1] != op1_i[W-1]);
            OP_SUB:  ovf = (op1_i[W-1] != op2_i[W-1]) && (dif[W-1] != op1_i[W-1]);
            default: ovf = 1'b0;
        endcase
    end

    assign mul_sgn = (req_i.aluop == OP_MULT);
    assign mul_a   = {{W{mul_sgn && op1_i[W-1]}}, op1_i};  // sign or zero extend
    assign mul_b   = {{W{mul_sgn && op2_i[W-1]}}, op2_i};
    assign product = mul_a * mul_b;

    always_comb begin
        grp_res = '0;
        case (req_i.aluop)
            OP_OR:              grp_res = op1_i | op2_i;
            OP_AND:             grp_res = op1_i & op2_i;
            OP_XOR:             grp_res = op1_i ^ op2_i;
            OP_NOR:             grp_res = ~(op1_i | op2_i);
            OP_SLL:             grp_res = op2_i << op1_i[4:0];
            OP_SRL:             grp_res = op2_i >> op1_i[4:0];
            OP_SRA:             grp_res = $signed(op2_i) >>> op1_i[4:0];
            OP_ADD, OP_ADDU:    grp_res = sum;
            OP_SUB, OP_SUBU:    grp_res = dif;
            OP_SLT:             grp_res = W'($signed(op1_i) < $signed(op2_i));
            OP_SLTU:            grp_res = W'(op1_i < op2_i);
            OP_MULT, OP_MULTU:  grp_res = product[W-1:0];
            OP_DIV, OP_DIVU:    grp_res = div_quot;
            OP_MFHI, OP_MFLO,
            OP_MTHI, OP_MTLO:   grp_res = op1_i;    // hi/lo already muxed in
            OP_MFC0:            grp_res = cp0_i;
            default:            grp_res = '0;
        endcase
    end

    assign div_signed = (req_i.aluop == OP_DIV);
    assign div_start  = (grp == GRP_DIV) && !div_busy && !div_done;
    assign ok_o       = (grp != GRP_DIV) || div_done;

    ex_divider div0 (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .start_i    (div_start),
        .signed_i   (div_signed),
        .dividend_i (op1_i),
        .divisor_i  (op2_i),
        .busy_o     (div_busy),
        .done_o     (div_done),
        .quot_o     (div_quot),
        .rem_o      (div_rem)
    );

    always_comb begin
        res_o.wdata        = grp_res;
        res_o.wd           = req_i.wd;
        res_o.wreg         = req_i.wreg && !ovf;
        res_o.exc_type     = req_i.exc_type | (ovf << `EX_EXC_OVF_BIT);
        res_o.instr_addr   = req_i.instr_addr;
        res_o.in_delayslot = req_i.in_delayslot;
    end

    always_comb begin
        hilo_wr_o = '0;
        case (grp)
            GRP_MUL:  hilo_wr_o = '{we: 1'b1, hi: product[2*W-1:W], lo: product[W-1:0]};
            GRP_DIV:  hilo_wr_o = '{we: div_done, hi: div_rem, lo: div_quot};
            GRP_MOVE: begin
                if (req_i.aluop == OP_MTHI) begin
                    hilo_wr_o = '{we: 1'b1, hi: op1_i, lo: hilo_i[W-1:0]};
                end else if (req_i.aluop == OP_MTLO) begin
                    hilo_wr_o = '{we: 1'b1, hi: hilo_i[2*W-1:W], lo: op1_i};
                end
            end
            default:  hilo_wr_o = '0;
        endcase
    end

    assign cp0_wr_o = '{we: (req_i.aluop == OP_MTC0), addr: req_i.rd, data: op2_i};

endmodule

`default_nettype wire

/* logic/ex_divider.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_divider
    import ex_op_pkg::*;
(
    input  wire                     clk_i,
    input  wire                     rst_n_i,

    input  wire                     start_i,
    input  wire                     signed_i,
    input  wire [`EX_DATA_W-1:0]    dividend_i,
    input  wire [`EX_DATA_W-1:0]    divisor_i,

    output logic                    busy_o,
    output logic                    done_o,
    output logic [`EX_DATA_W-1:0]   quot_o,
    output logic [`EX_DATA_W-1:0]   rem_o
);

    localparam int W     = `EX_DATA_W;
    localparam int CNT_W = $clog2(`EX_DIV_ITER);

    div_state_e         state_q;
    logic [CNT_W-1:0]   cnt_q;

    logic [W-1:0]       quo_q;      // dividend shifts out, quotient in
    logic [W-1:0]       rem_q;
    logic [W-1:0]       dsr_q;      // divisor magnitude
    logic               neg_q_q;
    logic               neg_r_q;

    logic               a_neg;
    logic               b_neg;
    logic [W-1:0]       a_mag;
    logic [W-1:0]       b_mag;
    logic               div_zero;
    logic [W:0]         shifted;
    logic [W:0]         diff;

    assign a_neg    = signed_i && dividend_i[W-1];
    assign b_neg    = signed_i && divisor_i[W-1];
    assign a_mag    = a_neg ? -dividend_i : dividend_i;
    assign b_mag    = b_neg ? -divisor_i : divisor_i;
    assign div_zero = (divisor_i == '0);

    assign shifted = {rem_q, quo_q[W-1]};
    assign diff    = shifted - {1'b0, dsr_q};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (start_i) begin
                        state_q <= div_zero ? DIV_DONE : DIV_RUN;
                        cnt_q   <= '0;
                    end
                end
                DIV_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(`EX_DIV_ITER - 1)) state_q <= DIV_DONE;
                end
                default: state_q <= DIV_IDLE;   // done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == DIV_IDLE && start_i) begin
            if (div_zero) begin
                quo_q   <= '1;
                rem_q   <= dividend_i;              // raw, no sign fix
                neg_q_q <= 1'b0;
                neg_r_q <= 1'b0;
            end else begin
                quo_q   <= a_mag;
                rem_q   <= '0;
                dsr_q   <= b_mag;
                neg_q_q <= a_neg ^ b_neg;
                neg_r_q <= a_neg;
            end
        end else if (state_q == DIV_RUN) begin
            rem_q <= diff[W] ? shifted[W-1:0] : diff[W-1:0];   // restore on borrow
            quo_q <= {quo_q[W-2:0], ~diff[W]};
        end
    end

    assign busy_o = (state_q == DIV_RUN);
    assign done_o = (state_q == DIV_DONE);
    assign quot_o = neg_q_q ? -quo_q : quo_q;
    assign rem_o  = neg_r_q ? -rem_q : rem_q;

endmodule

`default_nettype wire

/* logic/ex_operand_sel.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_operand_sel
    import ex_op_pkg::*;
    import ex_bus_pkg::*;
(
    input  wire alu_op_e                    aluop_i,
    input  wire [`EX_DATA_W-1:0]            reg1_i,
    input  wire [`EX_DATA_W-1:0]            reg2_i,

    input  wire [`EX_HILO_W-1:0]            hilo_i,      // committed {hi, lo}
    input  wire hilo_wr_t                   mem_hilo_i,
    input  wire hilo_wr_t                   wb_hilo_i,

    input  wire [`EX_CP0_ADDR_W-1:0]        rd_i,
    input  wire [`EX_DATA_W-1:0]            cp0_rdata_i,
    input  wire cp0_wr_t                    mem_cp0_i,
    input  wire cp0_wr_t                    wb_cp0_i,

    output logic [`EX_DATA_W-1:0]           op1_o,
    output logic [`EX_DATA_W-1:0]           op2_o,
    output logic [`EX_HILO_W-1:0]           hilo_o,
    output logic [`EX_DATA_W-1:0]           cp0_o
);

    logic mem_cp0_hit;
    logic wb_cp0_hit;

    assign mem_cp0_hit = mem_cp0_i.we && (mem_cp0_i.addr == rd_i);
    assign wb_cp0_hit  = wb_cp0_i.we && (wb_cp0_i.addr == rd_i);

    // youngest write wins
    always_comb begin
        if (mem_hilo_i.we) begin
            hilo_o = {mem_hilo_i.hi, mem_hilo_i.lo};
        end else if (wb_hilo_i.we) begin
            hilo_o = {wb_hilo_i.hi, wb_hilo_i.lo};
        end else begin
            hilo_o = hilo_i;
        end
    end

    always_comb begin
        if (mem_cp0_hit) begin
            cp0_o = mem_cp0_i.data;
        end else if (wb_cp0_hit) begin
            cp0_o = wb_cp0_i.data;
        end else begin
            cp0_o = cp0_rdata_i;
        end
    end

    always_comb begin
        case (aluop_i)
            OP_MFHI: op1_o = hilo_o[`EX_HILO_W-1:`EX_DATA_W];
            OP_MFLO: op1_o = hilo_o[`EX_DATA_W-1:0];
            default: op1_o = reg1_i;
        endcase
    end

    assign op2_o = reg2_i;

endmodule

`default_nettype wire

/* logic/ex_bus_pkg.sv */
`default_nettype none

`include "ex_params.svh"

package ex_bus_pkg;

    import ex_op_pkg::*;

    typedef struct packed {
        alu_op_e                    aluop;
        logic [`EX_DATA_W-1:0]      reg1;
        logic [`EX_DATA_W-1:0]      reg2;
        logic [`EX_REG_ADDR_W-1:0]  wd;           // destination gpr
        logic                       wreg;
        logic [`EX_CP0_ADDR_W-1:0]  rd;           // cp0 register address
        logic [`EX_EXC_W-1:0]       exc_type;
        logic [`EX_DATA_W-1:0]      instr_addr;
        logic                       in_delayslot;
    } ex_req_t;

    typedef struct packed {
        logic [`EX_DATA_W-1:0]      wdata;
        logic [`EX_REG_ADDR_W-1:0]  wd;
        logic                       wreg;
        logic [`EX_EXC_W-1:0]       exc_type;
        logic [`EX_DATA_W-1:0]      instr_addr;
        logic                       in_delayslot;
    } ex_res_t;

    typedef struct packed {
        logic                       we;
        logic [`EX_DATA_W-1:0]      hi;
        logic [`EX_DATA_W-1:0]      lo;
    } hilo_wr_t;

    typedef struct packed {
        logic                       we;
        logic [`EX_CP0_ADDR_W-1:0]  addr;
        logic [`EX_DATA_W-1:0]      data;
    } cp0_wr_t;

endpackage

`default_nettype wire

/* logic/ex_op_pkg.sv */
`default_nettype none

`include "ex_params.svh"

package ex_op_pkg;

    typedef enum logic [`EX_OP_W-1:0] {
        OP_NOP   = 5'd0,
        OP_OR    = 5'd1,
        OP_AND   = 5'd2,
        OP_XOR   = 5'd3,
        OP_NOR   = 5'd4,
        OP_SLL   = 5'd5,
        OP_SRL   = 5'd6,
        OP_SRA   = 5'd7,
        OP_ADD   = 5'd8,
        OP_ADDU  = 5'd9,
        OP_SUB   = 5'd10,
        OP_SUBU  = 5'd11,
        OP_SLT   = 5'd12,
        OP_SLTU  = 5'd13,
        OP_MULT  = 5'd14,
        OP_MULTU = 5'd15,
        OP_DIV   = 5'd16,
        OP_DIVU  = 5'd17,
        OP_MFHI  = 5'd18,
        OP_MFLO  = 5'd19,
        OP_MTHI  = 5'd20,
        OP_MTLO  = 5'd21,
        OP_MFC0  = 5'd22,
        OP_MTC0  = 5'd23
    } alu_op_e;

    typedef enum logic [2:0] {
        GRP_NONE, GRP_LOGIC, GRP_SHIFT, GRP_ARITH, GRP_MUL, GRP_DIV, GRP_MOVE, GRP_CP0
    } alu_grp_e;

    typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_DONE} div_state_e;

endpackage

`default_nettype wire

/* logic/ex_params.svh */
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// datapath widths
`define EX_DATA_W       32
`define EX_REG_ADDR_W   5
`define EX_CP0_ADDR_W   5

// exception word
`define EX_EXC_W        32
`define EX_EXC_OVF_BIT  12

// one quotient bit per iteration
`define EX_DIV_ITER     32

// derived
`define EX_HILO_W       (2 * `EX_DATA_W)
`define EX_OP_W         5

`endif
